//--- hdl/digit_pkg.sv
package digit_pkg;

    // ------------------------------------------------------------------------
    // grid and classifier constants
    // ------------------------------------------------------------------------
    localparam int GRID        = 28;           // bitmap side, cells
    localparam int GRID_CELLS  = GRID * GRID;  // 784 bits
    localparam int NUM_CLASSES = 10;           // one bit per digit
    localparam int LUMA_THRESH = 400;          // dark pixel below this

    // ------------------------------------------------------------------------
    // pixel and sync types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // camera side, 18 bits
    typedef struct packed {
        logic    vsync;   // high through active frame
        logic    de;      // active pixel
        rgb565_t pixel;
    } cam_pixel_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
    } video_sync_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888_t;

    typedef logic [GRID_CELLS-1:0]  digit_bitmap_t;  // bit row*GRID+col
    typedef logic [NUM_CLASSES-1:0] class_vec_t;     // bit k = strip cell k

    // luma field: top ten bits of the red/blue swapped word,
    // i.e. blue then green[5:1]
    function automatic logic [9:0] luma_of(rgb565_t p);
        logic [15:0] swapped;
        swapped = {p.blue, p.green, p.red};
        return swapped[15:6];
    endfunction

endpackage

//--- hdl/cam_sampler.sv
`timescale 1ns/1ps

module cam_sampler #(
    parameter int CAM_CELL_SHIFT = 4
) (
    input  logic                    video_clk,
    input  logic                    rst_n,
    input  digit_pkg::cam_pixel_t   cam_in,
    input  logic                    link_idle,
    output digit_pkg::digit_bitmap_t digit_img,
    output logic                    frame_latched
);
    import digit_pkg::*;

    localparam int CELL_MASK = (1 << CAM_CELL_SHIFT) - 1;

    logic          prev_de;
    logic          prev_vsync;
    logic [11:0]   cam_x;       // de cycles in line
    logic [10:0]   cam_y;       // lines in frame
    logic          sample_hit;
    logic          dark;
    logic          vsync_fall;
    digit_bitmap_t bin_shr;     // raster-order samples

    // ------------------------------------------------------------------------
    // column / line counters
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_de    <= 1'b0;
            prev_vsync <= 1'b0;
            cam_x      <= '0;
            cam_y      <= '0;
        end else begin
            prev_de    <= cam_in.de;
            prev_vsync <= cam_in.vsync;
            cam_x      <= cam_in.de ? cam_x + 12'd1 : 12'd0;
            if (!cam_in.vsync) begin
                cam_y <= '0;                    // blanking
            end else if (prev_de && !cam_in.de) begin
                cam_y <= cam_y + 11'd1;         // end of line
            end
        end
    end

    // thinning: grid-aligned pixel inside the 28x28 window
    assign sample_hit = cam_in.de
                     && ((cam_x & CELL_MASK) == 0)
                     && ((cam_y & CELL_MASK) == 0)
                     && ((cam_x >> CAM_CELL_SHIFT) < GRID)
                     && ((cam_y >> CAM_CELL_SHIFT) < GRID);

    assign dark       = luma_of(cam_in.pixel) < LUMA_THRESH;
    assign vsync_fall = prev_vsync && !cam_in.vsync;

    // new bit enters at the top, first sample drifts down to bit 0
    always_ff @(posedge video_clk) begin
        if (sample_hit) begin
            bin_shr <= {dark, bin_shr[GRID_CELLS-1:1]};
        end
    end

    // ------------------------------------------------------------------------
    // frame latch, skipped while the handshake is open
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            digit_img     <= '0;
            frame_latched <= 1'b0;
        end else begin
            frame_latched <= 1'b0;
            if (vsync_fall && link_idle) begin
                digit_img     <= bin_shr;
                frame_latched <= 1'b1;          // kicks class_link
            end
        end
    end

endmodule

//--- hdl/class_link.sv
`timescale 1ns/1ps

module class_link (
    input  logic                  video_clk,
    input  logic                  rst_n,
    input  logic                  frame_latched,
    output logic                  img_req,
    input  logic                  img_ack,
    input  digit_pkg::class_vec_t class_in,
    output digit_pkg::class_vec_t class_result,
    output logic                  link_idle
);
    import digit_pkg::*;

    // four-phase requester states
    typedef enum logic [1:0] {
        ST_IDLE,    // req low, ack low
        ST_REQ,     // req high until ack
        ST_DROP     // req low, wait for ack to fall
    } link_state_t;

    link_state_t state;

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            class_result <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_latched) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (img_ack) begin
                        class_result <= class_in;   // valid with ack
                        state        <= ST_DROP;
                    end
                end
                ST_DROP: begin
                    if (!img_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign img_req   = (state == ST_REQ);
    assign link_idle = (state == ST_IDLE) && !img_ack;  // both wires low

endmodule

//--- hdl/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  logic                   video_clk,
    input  logic                   rst_n,
    output digit_pkg::video_sync_t raw_sync,
    output logic [11:0]            pix_x,
    output logic [10:0]            pix_y
);
    import digit_pkg::*;

    localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_ON = H_ACTIVE + H_FRONT;   // sync after front porch
    localparam int V_SYNC_ON = V_ACTIVE + V_FRONT;

    logic [11:0] h_cnt;
    logic [10:0] v_cnt;

    // ------------------------------------------------------------------------
    // raster counters, active area first
    // ------------------------------------------------------------------------
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_TOTAL - 1) begin
            h_cnt <= '0;
            if (v_cnt == V_TOTAL - 1) begin
                v_cnt <= '0;                    // wrap frame
            end else begin
                v_cnt <= v_cnt + 11'd1;
            end
        end else begin
            h_cnt <= h_cnt + 12'd1;
        end
    end

    // sync decode, all active high
    always_comb begin
        raw_sync.de = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
        raw_sync.hs = (h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_ON + H_SYNC);
        raw_sync.vs = (v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_ON + V_SYNC);
    end

    // coordinates only meaningful while de
    assign pix_x = h_cnt;
    assign pix_y = v_cnt;

endmodule

//--- hdl/overlay_mixer.sv
`timescale 1ns/1ps

module overlay_mixer #(
    parameter int DISP_CELL_SHIFT = 4,
    parameter int BIN_X           = 50,
    parameter int BIN_Y           = 1,
    parameter int CLASS_X         = 1,
    parameter int CLASS_Y         = 18
) (
    input  logic                     video_clk,
    input  logic                     rst_n,
    input  digit_pkg::video_sync_t   raw_sync,
    input  logic [11:0]              pix_x,
    input  logic [10:0]              pix_y,
    input  digit_pkg::digit_bitmap_t digit_img,
    input  digit_pkg::class_vec_t    class_result,
    output digit_pkg::video_sync_t   video_sync,
    output digit_pkg::rgb888_t       video_rgb
);
    import digit_pkg::*;

    localparam int CLASS_SHIFT = DISP_CELL_SHIFT + 1;  // strip cells twice as big

    logic [11:0] bin_cx;        // bitmap cell coords
    logic [10:0] bin_cy;
    logic [11:0] cls_cx;        // strip cell coords
    logic [10:0] cls_cy;
    logic        in_bin;
    logic        in_cls;
    logic [4:0]  bin_row;
    logic [4:0]  bin_col;
    logic [9:0]  bin_idx;
    logic [3:0]  cls_idx;
    logic        cell_on;
    rgb888_t     rgb_next;

    // ------------------------------------------------------------------------
    // region tests
    // ------------------------------------------------------------------------
    assign bin_cx = pix_x >> DISP_CELL_SHIFT;
    assign bin_cy = pix_y >> DISP_CELL_SHIFT;
    assign cls_cx = pix_x >> CLASS_SHIFT;
    assign cls_cy = pix_y >> CLASS_SHIFT;

    assign in_bin = (bin_cx >= BIN_X) && (bin_cx < BIN_X + GRID)
                 && (bin_cy >= BIN_Y) && (bin_cy < BIN_Y + GRID);
    assign in_cls = (cls_cx >= CLASS_X) && (cls_cx < CLASS_X + NUM_CLASSES)
                 && (cls_cy == CLASS_Y);   // one cell high

    // offsets into bitmap / strip, only valid inside their region
    assign bin_row = 5'(bin_cy - 11'(BIN_Y));
    assign bin_col = 5'(bin_cx - 12'(BIN_X));
    assign bin_idx = 10'(bin_row) * 10'(GRID) + 10'(bin_col);
    assign cls_idx = 4'(cls_cx - 12'(CLASS_X));

    // ------------------------------------------------------------------------
    // pixel select
    // ------------------------------------------------------------------------
    always_comb begin
        cell_on  = 1'b0;
        rgb_next = '0;                          // black outside de
        if (raw_sync.de) begin
            if (in_bin) begin                   // bitmap wins over strip
                cell_on  = digit_img[bin_idx];
                rgb_next = {24{cell_on}};
            end else if (in_cls) begin
                cell_on  = class_result[cls_idx];
                rgb_next = {24{cell_on}};
            end else begin
                // gradient background
                rgb_next.red   = pix_x[7:0];
                rgb_next.green = pix_y[7:0];
                rgb_next.blue  = 8'hff;
            end
        end
    end

    // colour and sync leave together, one cycle behind raw timing
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            video_sync <= '0;
            video_rgb  <= '0;
        end else begin
            video_sync <= raw_sync;
            video_rgb  <= rgb_next;
        end
    end

endmodule

//--- hdl/digit_overlay_top.sv
`timescale 1ns/1ps

module digit_overlay_top #(
    parameter int CAM_CELL_SHIFT  = 4,
    parameter int DISP_CELL_SHIFT = 4,
    parameter int BIN_X           = 50,
    parameter int BIN_Y           = 1,
    parameter int CLASS_X         = 1,
    parameter int CLASS_Y         = 18,
    parameter int H_ACTIVE        = 1280,
    parameter int H_FRONT         = 110,
    parameter int H_SYNC          = 40,
    parameter int H_BACK          = 220,
    parameter int V_ACTIVE        = 720,
    parameter int V_FRONT         = 5,
    parameter int V_SYNC          = 5,
    parameter int V_BACK          = 20
) (
    input  logic                     video_clk,
    input  logic                     rst_n,
    input  digit_pkg::cam_pixel_t    cam_in,
    output logic                     img_req,
    input  logic                     img_ack,
    input  digit_pkg::class_vec_t    class_in,
    output digit_pkg::digit_bitmap_t digit_img,
    output digit_pkg::video_sync_t   video_sync,
    output digit_pkg::rgb888_t       video_rgb
);
    import digit_pkg::*;

    logic        link_idle;
    logic        frame_latched;
    class_vec_t  class_result;
    video_sync_t raw_sync;
    logic [11:0] pix_x;
    logic [10:0] pix_y;

    // ------------------------------------------------------------------------
    // capture side
    // ------------------------------------------------------------------------
    cam_sampler #(
        .CAM_CELL_SHIFT (CAM_CELL_SHIFT)
    ) i_cam_sampler (
        .video_clk     (video_clk),
        .rst_n         (rst_n),
        .cam_in        (cam_in),
        .link_idle     (link_idle),
        .digit_img     (digit_img),
        .frame_latched (frame_latched)
    );

    class_link i_class_link (
        .video_clk     (video_clk),
        .rst_n         (rst_n),
        .frame_latched (frame_latched),
        .img_req       (img_req),
        .img_ack       (img_ack),
        .class_in      (class_in),
        .class_result  (class_result),
        .link_idle     (link_idle)
    );

    // ------------------------------------------------------------------------
    // display side
    // ------------------------------------------------------------------------
    video_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) i_video_timing (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .raw_sync  (raw_sync),
        .pix_x     (pix_x),
        .pix_y     (pix_y)
    );

    overlay_mixer #(
        .DISP_CELL_SHIFT (DISP_CELL_SHIFT),
        .BIN_X           (BIN_X),
        .BIN_Y           (BIN_Y),
        .CLASS_X         (CLASS_X),
        .CLASS_Y         (CLASS_Y)
    ) i_overlay_mixer (
        .video_clk    (video_clk),
        .rst_n        (rst_n),
        .raw_sync     (raw_sync),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .digit_img    (digit_img),
        .class_result (class_result),
        .video_sync   (video_sync),
        .video_rgb    (video_rgb)
    );

endmodule

//--- tests/tb_frame_table.svh
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// columns: pixel seed mix, class answer, ack delay in cycles,
//          skip (frame ends while the handshake is open), settle (wait and scan display)
typedef struct packed {
    logic [15:0] seed;      // xor'ed into every random pixel
    logic [9:0]  cls;       // classifier answer for this frame
    logic [15:0] delay;     // cycles from req to ack
    logic        skip;      // frame expected to be dropped
    logic        settle;    // finish handshake, then check one display frame
} frame_row_t;

localparam int NUM_ROWS = 6;

localparam frame_row_t FRAME_TABLE [NUM_ROWS] = '{
    '{16'h1234, 10'h001, 16'd3,    1'b0, 1'b1},   // quick ack
    '{16'h00ff, 10'h200, 16'd12,   1'b0, 1'b1},   // top class bit
    '{16'hbeef, 10'h155, 16'd5000, 1'b0, 1'b0},   // slow ack, overlaps next frame
    '{16'h0f0f, 10'h3ff, 16'd0,    1'b1, 1'b1},   // dropped by back-pressure
    '{16'ha5a5, 10'h0aa, 16'd1,    1'b0, 1'b1},
    '{16'h7e81, 10'h000, 16'd20,   1'b0, 1'b1}    // strip all dark
};

`endif

//--- tests/tb_digit_overlay.sv
`timescale 1ns/1ps

module tb_digit_overlay;
    import digit_pkg::*;

    `include "tb_frame_table.svh"

    // small raster, short porches
    localparam int H_ACTIVE = 160;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 80;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    localparam int CAM_CELL_SHIFT  = 1;
    localparam int DISP_CELL_SHIFT = 1;
    localparam int BIN_X   = 4;
    localparam int BIN_Y   = 2;
    localparam int CLASS_X = 1;
    localparam int CLASS_Y = 16;          // strip at y 64..67, under the bitmap

    localparam int CAM_SIDE   = GRID << CAM_CELL_SHIFT;   // 56x56 camera frame
    localparam int CAM_HBLANK = 4;
    localparam int CAM_VBLANK = 4;

    logic          video_clk;
    logic          rst_n;
    cam_pixel_t    cam_in;
    logic          img_req;
    logic          img_ack;
    class_vec_t    class_in;
    digit_bitmap_t digit_img;
    video_sync_t   video_sync;
    rgb888_t       video_rgb;

    integer        seed = 50;
    int            err_cnt = 0;
    int            chk_cnt = 0;
    int            tmo_cnt = 0;
    int            ack_delay;              // handed to the classifier model
    class_vec_t    ack_class;
    digit_bitmap_t exp_next;               // bitmap of the frame being driven
    digit_bitmap_t exp_img;                // last accepted bitmap
    class_vec_t    exp_class;              // last accepted class answer

    digit_overlay_top #(
        .CAM_CELL_SHIFT  (CAM_CELL_SHIFT),
        .DISP_CELL_SHIFT (DISP_CELL_SHIFT),
        .BIN_X           (BIN_X),
        .BIN_Y           (BIN_Y),
        .CLASS_X         (CLASS_X),
        .CLASS_Y         (CLASS_Y),
        .H_ACTIVE        (H_ACTIVE),
        .H_FRONT         (H_FRONT),
        .H_SYNC          (H_SYNC),
        .H_BACK          (H_BACK),
        .V_ACTIVE        (V_ACTIVE),
        .V_FRONT         (V_FRONT),
        .V_SYNC          (V_SYNC),
        .V_BACK          (V_BACK)
    ) i_digit_overlay_top (
        .video_clk  (video_clk),
        .rst_n      (rst_n),
        .cam_in     (cam_in),
        .img_req    (img_req),
        .img_ack    (img_ack),
        .class_in   (class_in),
        .digit_img  (digit_img),
        .video_sync (video_sync),
        .video_rgb  (video_rgb)
    );

    initial begin
        video_clk = 1'b0;
        forever #10 video_clk = ~video_clk;    // 50 MHz
    end

    // ------------------------------------------------------------------------
    // expected display colour for active pixel (x, y)
    // ------------------------------------------------------------------------
    function automatic rgb888_t expected_rgb(input int x, input int y,
                                             input digit_bitmap_t img,
                                             input class_vec_t cls);
        int      bx;
        int      by;
        int      sx;
        int      sy;
        rgb888_t c;
        bx = (x >> DISP_CELL_SHIFT) - BIN_X;          // bitmap cell
        by = (y >> DISP_CELL_SHIFT) - BIN_Y;
        sx = (x >> (DISP_CELL_SHIFT + 1)) - CLASS_X;  // strip cells twice as big
        sy = (y >> (DISP_CELL_SHIFT + 1)) - CLASS_Y;
        if (bx >= 0 && bx < GRID && by >= 0 && by < GRID) begin
            c = {24{img[by * GRID + bx]}};
        end else if (sx >= 0 && sx < NUM_CLASSES && sy == 0) begin
            c = {24{cls[sx]}};
        end else begin
            c.red   = x[7:0];                         // gradient
            c.green = y[7:0];
            c.blue  = 8'hff;
        end
        return c;
    endfunction

    // ------------------------------------------------------------------------
    // one camera frame, expected bitmap built on the fly
    // ------------------------------------------------------------------------
    task automatic drive_camera_frame(input logic [15:0] mix);
        cam_pixel_t  nxt;
        logic [15:0] word;
        logic [9:0]  luma;
        int          x;
        int          y;
        int          n;
        nxt = '0;
        for (n = 0; n < CAM_VBLANK; n++) begin   // blanking, line count clears
            @(posedge video_clk);
            cam_in <= nxt;
        end
        nxt.vsync = 1'b1;
        for (n = 0; n < 2; n++) begin
            @(posedge video_clk);
            cam_in <= nxt;
        end
        for (y = 0; y < CAM_SIDE; y++) begin
            for (x = 0; x < CAM_SIDE; x++) begin
                @(posedge video_clk);
                word      = 16'($random(seed)) ^ mix;
                nxt.de    = 1'b1;
                nxt.pixel = word;
                cam_in   <= nxt;
                if ((x % (1 << CAM_CELL_SHIFT)) == 0 && (y % (1 << CAM_CELL_SHIFT)) == 0) begin
                    luma = {word[4:0], word[10:6]};   // blue, then top of green
                    exp_next[(y >> CAM_CELL_SHIFT) * GRID + (x >> CAM_CELL_SHIFT)] = luma < 400;
                end
            end
            nxt.de    = 1'b0;
            nxt.pixel = '0;
            for (n = 0; n < CAM_HBLANK; n++) begin
                @(posedge video_clk);
                cam_in <= nxt;
            end
        end
        @(posedge video_clk);
        nxt.vsync = 1'b0;                      // end of frame
        cam_in   <= nxt;
    endtask

    // ------------------------------------------------------------------------
    // raster checker, one display frame from vs rise to vs rise
    // ------------------------------------------------------------------------
    task automatic check_display_frame();
        video_sync_t cur;
        video_sync_t prev;
        rgb888_t     want;
        int          x;
        int          y;
        int          n;
        int          hs_len;
        int          hs_cnt;
        int          vs_len;
        logic        found;
        x      = 0;
        y      = 0;
        hs_len = 0;
        hs_cnt = 0;
        found  = 1'b0;
        @(posedge video_clk);
        prev = video_sync;
        for (n = 0; n < 2 * FRAME_CYCLES && !found; n++) begin
            @(posedge video_clk);
            found = video_sync.vs && !prev.vs;
            prev  = video_sync;
        end
        if (!found) begin
            tmo_cnt++;
            $display("timeout: no vsync pulse seen on the display output");
            return;
        end
        vs_len = 1;                            // rise cycle itself
        found  = 1'b0;
        for (n = 0; n < 2 * FRAME_CYCLES && !found; n++) begin
            @(posedge video_clk);
            cur = video_sync;
            if (cur.vs && !prev.vs) begin
                found = 1'b1;                  // next frame begins
            end else begin
                if (cur.de) begin
                    want = expected_rgb(x, y, exp_img, exp_class);
                    chk_cnt++;
                    if (video_rgb !== want) begin
                        err_cnt++;
                        $display("** Error @%0t: pixel (%0d,%0d) rgb %06h, expected %06h",
                                 $time, x, y, video_rgb, want);
                    end
                    x++;
                end else begin
                    if (prev.de) begin         // line just ended
                        chk_cnt++;
                        if (x != H_ACTIVE) begin
                            err_cnt++;
                            $display("** Error @%0t: line %0d has %0d de cycles, expected %0d",
                                     $time, y, x, H_ACTIVE);
                        end
                        y++;
                        x = 0;
                    end
                    chk_cnt++;
                    if (video_rgb !== 24'h0) begin
                        err_cnt++;
                        $display("** Error @%0t: rgb %06h outside de", $time, video_rgb);
                    end
                end
                if (cur.hs) begin
                    hs_len++;
                end else if (prev.hs) begin
                    chk_cnt++;
                    if (hs_len != H_SYNC) begin
                        err_cnt++;
                        $display("** Error @%0t: hs pulse %0d cycles, expected %0d",
                                 $time, hs_len, H_SYNC);
                    end
                    hs_cnt++;
                    hs_len = 0;
                end
                if (cur.vs) vs_len++;
                prev = cur;
            end
        end
        if (!found) begin
            tmo_cnt++;
            $display("timeout: display frame did not end with a second vsync pulse");
            return;
        end
        chk_cnt++;
        if (y != V_ACTIVE || hs_cnt != V_TOTAL || vs_len != V_SYNC * H_TOTAL) begin
            err_cnt++;
            $display("** Error @%0t: frame has %0d lines, %0d hs pulses, vs %0d cycles",
                     $time, y, hs_cnt, vs_len);
        end
    endtask

    // ------------------------------------------------------------------------
    // classifier model, four-phase responder
    // ------------------------------------------------------------------------
    initial begin : classifier_model
        int         delay;
        int         n;
        class_vec_t answer;
        img_ack  = 1'b0;
        class_in = '0;
        forever begin
            @(posedge video_clk);
            if (img_req && !img_ack) begin
                delay  = ack_delay;            // set before req rises
                answer = ack_class;
                for (n = 0; n < delay; n++) @(posedge video_clk);
                img_ack  <= 1'b1;
                class_in <= answer;
                n = 0;
                do begin
                    @(posedge video_clk);
                    n++;
                end while (img_req && n < 8);
                if (img_req) begin
                    tmo_cnt++;
                    $display("timeout: img_req stayed high after img_ack");
                end
                img_ack  <= 1'b0;
                class_in <= ~answer;           // junk once ack is gone
            end
        end
    end

    // ------------------------------------------------------------------------
    // main stimulus loop
    // ------------------------------------------------------------------------
    initial begin : main_flow
        frame_row_t row;
        int         r;
        int         n;
        logic       hit;
        rst_n     = 1'b0;
        cam_in    = '0;
        ack_delay = 0;
        ack_class = '0;
        exp_next  = '0;
        exp_img   = '0;
        exp_class = '0;
        for (n = 0; n < 16; n++) @(posedge video_clk);
        chk_cnt++;
        if (img_req !== 1'b0 || video_sync !== 3'b000 || video_rgb !== 24'h0
            || digit_img !== '0) begin
            err_cnt++;
            $display("** Error @%0t: outputs not cleared in reset", $time);
        end
        rst_n <= 1'b1;

        for (r = 0; r < NUM_ROWS; r++) begin
            row = FRAME_TABLE[r];
            drive_camera_frame(row.seed);
            if (!row.skip) begin
                ack_delay = row.delay;
                ack_class = row.cls;
                hit = 1'b0;
                for (n = 0; n < 8 && !hit; n++) begin
                    @(posedge video_clk);
                    hit = img_req;
                end
                if (!hit) begin
                    tmo_cnt++;
                    $display("timeout: img_req did not rise after frame %0d", r);
                end
                chk_cnt++;
                if (digit_img !== exp_next) begin
                    err_cnt++;
                    $display("** Error @%0t: digit_img mismatch after frame %0d", $time, r);
                end
                exp_img   = exp_next;
                exp_class = row.cls;
            end else begin
                // latch would land one edge after vsync falls
                for (n = 0; n < 3; n++) @(posedge video_clk);
                chk_cnt++;
                if (!(img_req || img_ack)) begin
                    err_cnt++;
                    $display("** Error @%0t: handshake closed before frame %0d ended", $time, r);
                end
                chk_cnt++;
                if (digit_img !== exp_img) begin
                    err_cnt++;
                    $display("** Error @%0t: busy link, digit_img changed in frame %0d",
                             $time, r);
                end
            end
            if (row.settle) begin
                hit = 1'b0;
                for (n = 0; n < 8000 && !hit; n++) begin
                    @(posedge video_clk);
                    hit = !img_req && !img_ack;
                end
                if (!hit) begin
                    tmo_cnt++;
                    $display("timeout: handshake of frame %0d never completed", r);
                end
                check_display_frame();         // class strip and bitmap on screen
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+tests
hdl/digit_pkg.sv
hdl/cam_sampler.sv
hdl/class_link.sv
hdl/video_timing.sv
hdl/overlay_mixer.sv
hdl/digit_overlay_top.sv
tests/tb_digit_overlay.sv
